// ==== all.f ====
+incdir+bench
common/wh_mem_pkg.sv
logic/wh_flit_fifo.sv
wh_test_mem/wh_test_mem.sv
logic/wh_resp_concentrator.sv
logic/wh_mem_top.sv
bench/tb_wh_mem.sv

// ==== bench/wh_mem_ref.svh ====
`ifndef WH_MEM_REF_SVH
`define WH_MEM_REF_SVH

// expected contents of each link's memory, word index is block * 4 + word
logic [wh_mem_pkg::flit_width_lp-1:0] ref_mem [wh_mem_pkg::num_links_lp][wh_mem_pkg::mem_els_lp];

// expected fill flits per link, header then the block words
logic [wh_mem_pkg::flit_width_lp-1:0] exp_q0 [$];
logic [wh_mem_pkg::flit_width_lp-1:0] exp_q1 [$];

function automatic void clear_ref();
  for (int l = 0; l < wh_mem_pkg::num_links_lp; l++) begin
    for (int w = 0; w < wh_mem_pkg::mem_els_lp; w++) begin
      ref_mem[l][w] = '0;   // unwritten words read as zero
    end
  end
endfunction

function automatic int word_index(input logic [3:0] block, input int word);
  return int'(block) * wh_mem_pkg::block_words_lp + word;
endfunction

// word w of the block is bits w*32 and up
function automatic void apply_write(input int link, input logic [3:0] block,
                                    input logic [3:0] mask, input logic [127:0] words);
  for (int w = 0; w < wh_mem_pkg::block_words_lp; w++) begin
    if (mask[w]) ref_mem[link][word_index(block, w)] = words[w*32 +: 32];
  end
endfunction

function automatic logic [31:0] fill_header(input logic [3:0] src_cord,
                                            input logic [1:0] src_cid);
  wh_mem_pkg::wh_header_flit_s hdr;
  hdr = '0;
  hdr.cord = src_cord;   // fill goes back to the requester
  hdr.cid = src_cid;
  hdr.len = 4'd4;
  return hdr;
endfunction

function automatic void push_expected(input int link, input logic [31:0] flit);
  if (link == 0) exp_q0.push_back(flit);
  else exp_q1.push_back(flit);
endfunction

function automatic logic [31:0] pop_expected(input int link);
  if (link == 0) return exp_q0.pop_front();
  return exp_q1.pop_front();
endfunction

function automatic int queued(input int link);
  if (link == 0) return exp_q0.size();
  return exp_q1.size();
endfunction

function automatic void expect_fill(input int link, input logic [3:0] src_cord,
                                    input logic [1:0] src_cid, input logic [3:0] block);
  push_expected(link, fill_header(src_cord, src_cid));
  for (int w = 0; w < wh_mem_pkg::block_words_lp; w++) begin
    push_expected(link, ref_mem[link][word_index(block, w)]);
  end
endfunction

`endif

// ==== bench/tb_wh_mem.sv ====
module tb_wh_mem;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int packets_lp = 120;
  localparam logic [31:0] seed_lp = 32'hd9d0_19c9;
  // longest packet is 7 flits, 4 cycles per flit on each link
  localparam int timeout_cycles_lp = packets_lp * 7 * wh_mem_pkg::num_links_lp * 4;

  logic clk_i;
  logic reset_i;
  wh_mem_pkg::wh_link_fwd_s [wh_mem_pkg::num_links_lp-1:0] req_fwd;
  wh_mem_pkg::wh_link_rev_s [wh_mem_pkg::num_links_lp-1:0] req_rev;
  wh_mem_pkg::wh_link_fwd_s resp_fwd;
  wh_mem_pkg::wh_link_rev_s resp_rev;

  wh_mem_pkg::wh_link_fwd_s drv_fwd [wh_mem_pkg::num_links_lp];
  logic [31:0] stim_lfsr;
  logic [31:0] ready_lfsr;
  int cycle_count;

  logic in_packet;   // compare side is inside a fill packet
  int cur_link;
  int data_left;

  `include "wh_mem_ref.svh"

  assign req_fwd = {drv_fwd[1], drv_fwd[0]};

  wh_mem_top u_wh_mem_top (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_fwd_i (req_fwd),
    .req_rev_o (req_rev),
    .resp_fwd_o(resp_fwd),
    .resp_rev_i(resp_rev)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] bits;
    logic fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = state[31] ^ state[21] ^ state[1] ^ state[0];
      state = {state[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] expd);
    $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, expd);
    $display("Verification failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "stopped on a failed check");
  endtask

  // first cycle out of reset, nothing may be offered or accepted yet
  task automatic check_idle_after_reset();
    @(negedge clk_i);
    assert (req_rev == '0 && !resp_fwd.v)
      else report_failure("request ready or response valid high right after reset");
  endtask

  // call right after a rising edge, returns on the edge that takes the flit
  task automatic send_flit(input int link, input logic [31:0] flit);
    drv_fwd[link].v <= 1'b1;
    drv_fwd[link].data <= flit;
    do begin
      @(negedge clk_i);
    end while (!req_rev[link].ready_and);
    @(posedge clk_i);
    drv_fwd[link].v <= 1'b0;
  endtask

  task automatic drive_link(input int link);
    wh_mem_pkg::wh_header_flit_s hdr;
    logic [1:0] op_sel;
    logic [3:0] block;
    logic [3:0] offset;
    logic [3:0] mask;
    logic [127:0] words;
    for (int p = 0; p < packets_lp; p++) begin
      op_sel = 2'(take_bits(stim_lfsr, 2));
      block = 4'(take_bits(stim_lfsr, 4));
      offset = 4'(take_bits(stim_lfsr, 4));   // byte offset, ignored by the memory
      mask = 4'(take_bits(stim_lfsr, 4));
      hdr = '0;
      hdr.cord = 4'(link);
      hdr.src_cord = 4'(link + 3);
      hdr.src_cid = 2'(take_bits(stim_lfsr, 2));
      if (op_sel == 2'd1) begin
        hdr.opcode = wh_mem_pkg::e_wh_write_non_masked;
        hdr.len = 4'd5;
        mask = 4'hf;
      end else if (op_sel == 2'd2) begin
        hdr.opcode = wh_mem_pkg::e_wh_write_masked;
        hdr.len = 4'd6;
      end else begin
        hdr.opcode = wh_mem_pkg::e_wh_read;
        hdr.len = 4'd1;
      end
      send_flit(link, hdr);
      send_flit(link, {24'b0, block, offset});
      if (hdr.opcode == wh_mem_pkg::e_wh_read) begin
        expect_fill(link, hdr.src_cord, hdr.src_cid, block);
      end else begin
        if (hdr.opcode == wh_mem_pkg::e_wh_write_masked) send_flit(link, {28'b0, mask});
        for (int w = 0; w < 4; w++) begin
          words[w*32 +: 32] = take_bits(stim_lfsr, 32);
        end
        for (int w = 0; w < 4; w++) begin
          send_flit(link, words[w*32 +: 32]);
        end
        apply_write(link, block, mask, words);
      end
      if (take_bits(stim_lfsr, 1) != 0) @(posedge clk_i);   // idle gap
    end
  endtask

  initial begin
    reset_i = 1'b1;
    drv_fwd[0] = '0;
    drv_fwd[1] = '0;
    stim_lfsr = seed_lp;
    clear_ref();
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    fork
      drive_link(0);
      drive_link(1);
      check_idle_after_reset();
    join
    while (queued(0) != 0 || queued(1) != 0 || in_packet) @(posedge clk_i);
    repeat (20) @(posedge clk_i);   // a stray flit would still show up here
    $display("Verification passed");
    $finish;
  end

  // output back-pressure, ready three cycles in four
  initial begin
    resp_rev.ready_and = 1'b0;
    ready_lfsr = seed_lp;
    forever begin
      @(posedge clk_i);
      resp_rev.ready_and <= (2'(take_bits(ready_lfsr, 2)) != 2'd0);
    end
  end

  // transfer happens on the next rising edge
  always @(negedge clk_i) begin : compare
    logic [31:0] got;
    logic [31:0] expd;
    wh_mem_pkg::wh_header_flit_s hdr;
    if (reset_i) begin
      in_packet = 1'b0;
      cur_link = 0;
      data_left = 0;
    end else if (resp_fwd.v && resp_rev.ready_and) begin
      got = resp_fwd.data;
      hdr = got;
      if (!in_packet) begin
        assert (hdr.cord == 4'd3 || hdr.cord == 4'd4)
          else report_failure($sformatf("fill header names cord %0d, no link has it",
                                        hdr.cord));
        cur_link = int'(hdr.cord) - 3;
        assert (queued(cur_link) > 0)
          else report_failure($sformatf("fill arrived for link %0d with no read pending",
                                        cur_link));
        expd = pop_expected(cur_link);
        assert (got == expd)
          else report_mismatch($sformatf("link %0d fill header", cur_link), got, expd);
        in_packet = 1'b1;
        data_left = 4;
      end else begin
        assert (queued(cur_link) > 0)
          else report_failure($sformatf("extra data flit in a fill for link %0d", cur_link));
        expd = pop_expected(cur_link);
        assert (got == expd)
          else report_mismatch($sformatf("link %0d fill word %0d", cur_link, 4 - data_left),
                               got, expd);
        data_left--;
        if (data_left == 0) in_packet = 1'b0;
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles_lp) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("responses stopped arriving, run not finished after %0d cycles", cycle_count);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

endmodule

// ==== common/wh_mem_pkg.sv ====
package wh_mem_pkg;

  // one flit carries one dma word
  localparam int flit_width_lp = 32;
  localparam int cord_width_lp = 4;
  localparam int cid_width_lp = 2;
  localparam int len_width_lp = 4;   // flits after the header

  localparam int block_words_lp = 4;
  localparam int count_width_lp = 2;

  // test memory geometry, in words
  localparam int mem_els_lp = 64;
  localparam int mem_addr_width_lp = 6;
  localparam int block_offset_width_lp = 4;   // byte offset inside a block

  localparam int num_links_lp = 2;

  localparam int header_unused_width_lp = flit_width_lp - 2 - 2 * cid_width_lp
    - 2 * cord_width_lp - len_width_lp;

  typedef enum logic [1:0] {
    e_wh_read = 2'b00,
    e_wh_write_non_masked = 2'b01,
    e_wh_write_masked = 2'b10
  } wh_opcode_e;

  typedef struct packed {
    logic [header_unused_width_lp-1:0] unused;
    wh_opcode_e opcode;
    logic [cid_width_lp-1:0] src_cid;
    logic [cord_width_lp-1:0] src_cord;
    logic [len_width_lp-1:0] len;
    logic [cid_width_lp-1:0] cid;
    logic [cord_width_lp-1:0] cord;
  } wh_header_flit_s;

  // sender side of a link
  typedef struct packed {
    logic v;
    logic [flit_width_lp-1:0] data;
  } wh_link_fwd_s;

  // receiver side of a link
  typedef struct packed {
    logic ready_and;
  } wh_link_rev_s;

endpackage

// ==== logic/wh_flit_fifo.sv ====
module wh_flit_fifo #(
  parameter type payload_t = logic [wh_mem_pkg::flit_width_lp-1:0]
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_and_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  payload_t slot_r [2];
  logic wptr_r, rptr_r;
  logic [1:0] count_r, count_n;
  logic ready_r;
  logic enq, deq;

  assign enq = v_i & ready_and_o;
  assign deq = yumi_i;

  always_comb begin
    count_n = count_r;
    if (enq && !deq) count_n = count_r + 2'd1;
    else if (deq && !enq) count_n = count_r - 2'd1;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= 1'b0;
      rptr_r <= 1'b0;
      count_r <= 2'd0;
      ready_r <= 1'b0;   // held off for one cycle out of reset
    end else begin
      if (enq) wptr_r <= ~wptr_r;
      if (deq) rptr_r <= ~rptr_r;
      count_r <= count_n;
      ready_r <= (count_n != 2'd2);
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) slot_r[wptr_r] <= data_i;
  end

  assign ready_and_o = ready_r;
  assign v_o = (count_r != 2'd0);
  assign data_o = slot_r[rptr_r];

  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    enq |-> (count_r != 2'd2));
  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> (count_r != 2'd0));

endmodule

// ==== logic/wh_mem_top.sv ====
module wh_mem_top (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  wh_mem_pkg::wh_link_fwd_s [wh_mem_pkg::num_links_lp-1:0] req_fwd_i,
  output wh_mem_pkg::wh_link_rev_s [wh_mem_pkg::num_links_lp-1:0] req_rev_o,
  output wh_mem_pkg::wh_link_fwd_s                               resp_fwd_o,
  input  wh_mem_pkg::wh_link_rev_s                               resp_rev_i
);

  wh_mem_pkg::wh_link_fwd_s [wh_mem_pkg::num_links_lp-1:0] mem_fwd;   // fifo to memory
  wh_mem_pkg::wh_link_rev_s [wh_mem_pkg::num_links_lp-1:0] mem_rev;
  wh_mem_pkg::wh_link_fwd_s [wh_mem_pkg::num_links_lp-1:0] fill_fwd;  // memory to merge
  wh_mem_pkg::wh_link_rev_s [wh_mem_pkg::num_links_lp-1:0] fill_rev;
  wh_mem_pkg::wh_link_fwd_s merged_fwd;
  wh_mem_pkg::wh_link_rev_s merged_rev;

  for (genvar i = 0; i < wh_mem_pkg::num_links_lp; i++) begin : g_link
    wh_flit_fifo #(
      .payload_t(logic [wh_mem_pkg::flit_width_lp-1:0])
    ) u_req_fifo (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .v_i        (req_fwd_i[i].v),
      .data_i     (req_fwd_i[i].data),
      .ready_and_o(req_rev_o[i].ready_and),
      .v_o        (mem_fwd[i].v),
      .data_o     (mem_fwd[i].data),
      .yumi_i     (mem_fwd[i].v & mem_rev[i].ready_and)
    );

    wh_test_mem u_test_mem (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .link_fwd_i(mem_fwd[i]),
      .link_rev_o(mem_rev[i]),
      .fill_fwd_o(fill_fwd[i]),
      .fill_rev_i(fill_rev[i])
    );
  end

  wh_resp_concentrator u_resp_conc (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .in_fwd_i (fill_fwd),
    .in_rev_o (fill_rev),
    .out_fwd_o(merged_fwd),
    .out_rev_i(merged_rev)
  );

  wh_flit_fifo #(
    .payload_t(logic [wh_mem_pkg::flit_width_lp-1:0])
  ) u_resp_fifo (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .v_i        (merged_fwd.v),
    .data_i     (merged_fwd.data),
    .ready_and_o(merged_rev.ready_and),
    .v_o        (resp_fwd_o.v),
    .data_o     (resp_fwd_o.data),
    .yumi_i     (resp_fwd_o.v & resp_rev_i.ready_and)
  );

endmodule

// ==== logic/wh_resp_concentrator.sv ====
module wh_resp_concentrator (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  wh_mem_pkg::wh_link_fwd_s [wh_mem_pkg::num_links_lp-1:0] in_fwd_i,
  output wh_mem_pkg::wh_link_rev_s [wh_mem_pkg::num_links_lp-1:0] in_rev_o,
  output wh_mem_pkg::wh_link_fwd_s                               out_fwd_o,
  input  wh_mem_pkg::wh_link_rev_s                               out_rev_i
);

  logic locked_r;
  logic grant_r;   // input holding the lock
  logic last_r;    // winner of the previous arbitration
  logic [wh_mem_pkg::len_width_lp-1:0] flits_left_r;

  logic pick;
  logic sel;
  logic accept;

  wh_mem_pkg::wh_header_flit_s header_in;

  // round-robin pick when unlocked
  always_comb begin
    if (in_fwd_i[0].v && in_fwd_i[1].v) begin
      pick = ~last_r;
    end else if (in_fwd_i[1].v) begin
      pick = 1'b1;
    end else begin
      pick = 1'b0;
    end
  end

  assign sel = locked_r ? grant_r : pick;

  assign out_fwd_o = in_fwd_i[sel];
  assign accept = out_fwd_o.v & out_rev_i.ready_and;
  assign header_in = wh_mem_pkg::wh_header_flit_s'(out_fwd_o.data);

  always_comb begin
    for (int i = 0; i < wh_mem_pkg::num_links_lp; i++) begin
      in_rev_o[i].ready_and = out_rev_i.ready_and && (sel == i[0]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      locked_r <= 1'b0;
      grant_r <= 1'b0;
      last_r <= 1'b1;   // input 0 goes first
      flits_left_r <= '0;
    end else if (accept) begin
      if (!locked_r) begin
        // header accepted, hold the grant for the body
        last_r <= sel;
        grant_r <= sel;
        flits_left_r <= header_in.len;
        locked_r <= (header_in.len != '0);
      end else begin
        flits_left_r <= flits_left_r - 1'b1;
        if (flits_left_r == wh_mem_pkg::len_width_lp'(1)) locked_r <= 1'b0;
      end
    end
  end

  a_other_blocked: assert property (@(posedge clk_i) disable iff (reset_i)
    locked_r |-> !in_rev_o[~grant_r].ready_and);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, then run; the exit status is the simulator's
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_wh_mem -o tb_wh_mem -f all.f \
  && ./obj_dir/tb_wh_mem \
  || exit 1

// ==== wh_test_mem/wh_test_mem.sv ====
module wh_test_mem (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  wh_mem_pkg::wh_link_fwd_s  link_fwd_i,
  output wh_mem_pkg::wh_link_rev_s  link_rev_o,
  output wh_mem_pkg::wh_link_fwd_s  fill_fwd_o,
  input  wh_mem_pkg::wh_link_rev_s  fill_rev_i
);

  typedef enum logic [2:0] {
    s_reset,
    s_ready,
    s_recv_addr,
    s_recv_mask,
    s_recv_data,
    s_send_header,
    s_send_data
  } mem_state_e;

  mem_state_e state_r, state_n;

  // request fields captured from the incoming packet
  wh_mem_pkg::wh_opcode_e opcode_r, opcode_n;
  logic [wh_mem_pkg::cord_width_lp-1:0] src_cord_r, src_cord_n;
  logic [wh_mem_pkg::cid_width_lp-1:0] src_cid_r, src_cid_n;
  logic [wh_mem_pkg::flit_width_lp-1:0] addr_r, addr_n;
  logic [wh_mem_pkg::block_words_lp-1:0] mask_r, mask_n;

  // word counter within the block
  logic [wh_mem_pkg::count_width_lp-1:0] count_r, count_n;
  logic last_word;

  assign last_word =
    (count_r == wh_mem_pkg::count_width_lp'(wh_mem_pkg::block_words_lp - 1));

  wh_mem_pkg::wh_header_flit_s header_in, header_out;
  assign header_in = wh_mem_pkg::wh_header_flit_s'(link_fwd_i.data);

  always_comb begin
    header_out = '0;
    header_out.cord = src_cord_r;
    header_out.cid = src_cid_r;
    header_out.len = wh_mem_pkg::len_width_lp'(wh_mem_pkg::block_words_lp);
  end

  // memory array
  logic mem_we;
  logic word_sel;
  logic [wh_mem_pkg::mem_addr_width_lp-1:0] mem_addr;
  logic [wh_mem_pkg::flit_width_lp-1:0] mem_r [wh_mem_pkg::mem_els_lp];
  logic [wh_mem_pkg::flit_width_lp-1:0] mem_r_data, mem_r_data_filtered;

  // block number above the byte offset, word from the counter
  assign mem_addr = {
    addr_r[wh_mem_pkg::block_offset_width_lp +:
           (wh_mem_pkg::mem_addr_width_lp - wh_mem_pkg::count_width_lp)],
    count_r
  };

  assign word_sel = mask_r[count_r];

  always_ff @(posedge clk_i) begin
    if (mem_we && word_sel) begin
      mem_r[mem_addr] <= link_fwd_i.data;
    end
  end

  assign mem_r_data = mem_r[mem_addr];

  // never-written words come back as zero
  always_comb begin
    for (int b = 0; b < wh_mem_pkg::flit_width_lp; b++) begin
      if (mem_r_data[b] === 1'bx) mem_r_data_filtered[b] = 1'b0;
      else mem_r_data_filtered[b] = mem_r_data[b];
    end
  end

  always_comb begin
    state_n = state_r;
    opcode_n = opcode_r;
    src_cord_n = src_cord_r;
    src_cid_n = src_cid_r;
    addr_n = addr_r;
    mask_n = mask_r;
    count_n = count_r;
    mem_we = 1'b0;
    link_rev_o = '0;
    fill_fwd_o = '0;

    case (state_r)
      s_reset: begin
        state_n = s_ready;
      end

      s_ready: begin
        link_rev_o.ready_and = 1'b1;
        if (link_fwd_i.v) begin
          opcode_n = header_in.opcode;
          src_cord_n = header_in.src_cord;
          src_cid_n = header_in.src_cid;
          state_n = s_recv_addr;
        end
      end

      s_recv_addr: begin
        link_rev_o.ready_and = 1'b1;
        if (link_fwd_i.v) begin
          addr_n = link_fwd_i.data;
          count_n = '0;
          if (opcode_r == wh_mem_pkg::e_wh_read) begin
            state_n = s_send_header;
          end else if (opcode_r == wh_mem_pkg::e_wh_write_masked) begin
            state_n = s_recv_mask;
          end else begin
            mask_n = '1;   // every word written
            state_n = s_recv_data;
          end
        end
      end

      s_recv_mask: begin
        link_rev_o.ready_and = 1'b1;
        if (link_fwd_i.v) begin
          mask_n = link_fwd_i.data[0 +: wh_mem_pkg::block_words_lp];
          state_n = s_recv_data;
        end
      end

      s_recv_data: begin
        link_rev_o.ready_and = 1'b1;
        if (link_fwd_i.v) begin
          mem_we = 1'b1;
          count_n = count_r + 1'b1;   // wraps to zero after the last word
          if (last_word) state_n = s_ready;
        end
      end

      s_send_header: begin
        fill_fwd_o.v = 1'b1;
        fill_fwd_o.data = header_out;
        if (fill_rev_i.ready_and) state_n = s_send_data;
      end

      s_send_data: begin
        fill_fwd_o.v = 1'b1;
        fill_fwd_o.data = mem_r_data_filtered;
        if (fill_rev_i.ready_and) begin
          count_n = count_r + 1'b1;
          if (last_word) state_n = s_ready;
        end
      end

      default: begin
        state_n = s_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_reset;
      count_r <= '0;
    end else begin
      state_r <= state_n;
      count_r <= count_n;
    end
  end

  always_ff @(posedge clk_i) begin
    opcode_r <= opcode_n;
    src_cord_r <= src_cord_n;
    src_cid_r <= src_cid_n;
    addr_r <= addr_n;
    mask_r <= mask_n;
  end

  // header opcode comes from the cache side, check it on arrival
  a_opcode_known: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == s_ready && link_fwd_i.v) |->
      (header_in.opcode inside {wh_mem_pkg::e_wh_read,
                                wh_mem_pkg::e_wh_write_non_masked,
                                wh_mem_pkg::e_wh_write_masked}));

  a_fill_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (fill_fwd_o.v && !fill_rev_i.ready_and) |=>
      (fill_fwd_o.v && $stable(fill_fwd_o.data)));

endmodule
